/* Makefile */
VERILATOR ?= verilator
TOP       ?= mam_tb
FILELIST  ?= mam.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= ** PASS **

SRCS := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -F -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* mam.f */
source/mam_pkg.sv
source/mam_cmd_decode.sv
source/mam_ahb_master.sv
source/mam_resp_gen.sv
source/mam_ahb_sram.sv
source/mam_top.sv
verif/mam_tb.sv

/* source/mam_ahb_master.sv */
`timescale 1ns/1ps

module mam_ahb_master (
  input  logic                             clk_i,
  input  logic                             rst_i,

  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  logic                             req_we_i,
  input  logic [mam_pkg::MAM_PLEN-1:0]     req_addr_i,
  input  logic                             req_burst_i,
  input  logic [mam_pkg::MAM_BEATS_W-1:0]  req_beats_i,

  input  logic                             write_valid_i,
  input  logic [mam_pkg::MAM_XLEN-1:0]     write_data_i,
  output logic                             write_ready_o,

  output logic                             read_valid_o,
  output logic [mam_pkg::MAM_XLEN-1:0]     read_data_o,
  input  logic                             read_ready_i,
  output logic                             wr_done_o,

  output logic                             ahb3_hsel_o,
  output logic [mam_pkg::MAM_PLEN-1:0]     ahb3_haddr_o,
  output logic [mam_pkg::MAM_XLEN-1:0]     ahb3_hwdata_o,
  input  logic [mam_pkg::MAM_XLEN-1:0]     ahb3_hrdata_i,
  output logic                             ahb3_hwrite_o,
  output logic [2:0]                       ahb3_hsize_o,
  output logic [2:0]                       ahb3_hburst_o,
  output logic [3:0]                       ahb3_hprot_o,
  output logic [1:0]                       ahb3_htrans_o,
  output logic                             ahb3_hmastlock_o,
  input  logic                             ahb3_hready_i,
  input  logic                             ahb3_hresp_i
);
  import mam_pkg::*;

  mam_bus_state_e state_q;
  mam_bus_state_e state_d;

  logic                   hwrite_d;
  logic [2:0]             hburst_d;
  logic [1:0]             htrans_q;
  logic [1:0]             htrans_d;
  logic [MAM_PLEN-1:0]    addr_d;
  logic [MAM_XLEN-1:0]    wdata_q;
  logic [MAM_XLEN-1:0]    wdata_d;
  logic [MAM_XLEN-1:0]    rdata_q;
  logic [MAM_XLEN-1:0]    rdata_d;
  logic [MAM_BEATS_W-1:0] beats_q;
  logic [MAM_BEATS_W-1:0] beats_d;
  logic                   single;  // Request moves exactly one word

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= ST_IDLE;
      ahb3_hburst_o <= 3'b000;
      htrans_q      <= 2'b00;
    end else begin
      state_q       <= state_d;
      ahb3_hburst_o <= hburst_d;
      htrans_q      <= htrans_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ahb3_hwrite_o <= hwrite_d;
    ahb3_haddr_o  <= addr_d;
    wdata_q       <= wdata_d;
    rdata_q       <= rdata_d;
    beats_q       <= beats_d;
  end

  assign single = !req_burst_i || (req_beats_i == MAM_BEATS_W'(1));

  assign ahb3_hwdata_o    = wdata_q;
  assign read_data_o      = rdata_q;
  assign ahb3_hsize_o     = 3'b001;  // Halfword, no sub-word accesses
  assign ahb3_hprot_o     = 4'b1111;
  assign ahb3_hmastlock_o = ahb3_hsel_o;
  assign ahb3_htrans_o    = ahb3_hsel_o ? htrans_q : 2'b00;

  always_comb begin
    state_d  = state_q;
    hwrite_d = ahb3_hwrite_o;
    hburst_d = ahb3_hburst_o;
    htrans_d = htrans_q;
    addr_d   = ahb3_haddr_o;
    wdata_d  = wdata_q;
    rdata_d  = rdata_q;
    beats_d  = beats_q;

    ahb3_hsel_o   = 1'b0;
    req_ready_o   = 1'b0;
    write_ready_o = 1'b0;
    read_valid_o  = 1'b0;
    wr_done_o     = 1'b0;

    case (state_q)
      ST_IDLE: begin
        // Wait for a drained response buffer so a write ack always fits
        req_ready_o = read_ready_i;
        beats_d     = req_beats_i;
        addr_d      = req_addr_i;
        if (req_valid_i && read_ready_i) begin
          hwrite_d = req_we_i;
          htrans_d = 2'b10;  // NONSEQ
          hburst_d = single ? 3'b111 : 3'b010;
          if (!req_we_i) begin
            state_d = ST_READ;
          end else begin
            state_d = single ? ST_WRITE_LAST_WAIT : ST_WRITE_WAIT;
          end
        end
      end
      ST_WRITE_LAST_WAIT: begin
        write_ready_o = 1'b1;
        if (write_valid_i) begin
          wdata_d = write_data_i;
          state_d = ST_WRITE_LAST;
        end
      end
      ST_WRITE_LAST: begin
        ahb3_hsel_o = 1'b1;
        if (ahb3_hready_i) begin
          wr_done_o = 1'b1;
          hburst_d  = 3'b000;
          state_d   = ST_IDLE;
        end
      end
      ST_WRITE_WAIT: begin
        write_ready_o = 1'b1;
        if (write_valid_i) begin
          wdata_d = write_data_i;
          beats_d = beats_q - 1'b1;
          state_d = ST_WRITE;
        end
      end
      ST_WRITE: begin
        ahb3_hsel_o = 1'b1;
        if (ahb3_hready_i) begin
          // Beat done, next word may be taken in the same cycle
          write_ready_o = 1'b1;
          addr_d        = ahb3_haddr_o + MAM_PLEN'(MAM_BYTES);
          htrans_d      = 2'b11;  // SEQ
          if (beats_q == MAM_BEATS_W'(1)) begin
            hburst_d = 3'b111;
            if (write_valid_i) begin
              wdata_d = write_data_i;
              state_d = ST_WRITE_LAST;
            end else begin
              state_d = ST_WRITE_LAST_WAIT;
            end
          end else if (write_valid_i) begin
            wdata_d = write_data_i;
            beats_d = beats_q - 1'b1;
          end else begin
            state_d = ST_WRITE_WAIT;
          end
        end
      end
      ST_READ: begin
        ahb3_hsel_o = 1'b1;
        if (ahb3_hready_i) begin
          rdata_d  = ahb3_hresp_i ? '0 : ahb3_hrdata_i;  // Error beats read as zero
          beats_d  = beats_q - 1'b1;
          addr_d   = ahb3_haddr_o + MAM_PLEN'(MAM_BYTES);
          htrans_d = 2'b11;
          state_d  = ST_READ_WAIT;
        end
      end
      ST_READ_WAIT: begin
        read_valid_o = 1'b1;  // Bus stalls here under back-pressure
        if (read_ready_i) begin
          if (beats_q == MAM_BEATS_W'(1)) hburst_d = 3'b111;
          if (beats_q == '0) begin
            hburst_d = 3'b000;
            state_d  = ST_IDLE;
          end else begin
            state_d = ST_READ;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

endmodule

/* source/mam_ahb_sram.sv */
`timescale 1ns/1ps

module mam_ahb_sram (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         hsel_i,
  input  logic [mam_pkg::MAM_PLEN-1:0] haddr_i,
  input  logic [mam_pkg::MAM_XLEN-1:0] hwdata_i,
  input  logic                         hwrite_i,
  output logic [mam_pkg::MAM_XLEN-1:0] hrdata_o,
  output logic                         hready_o,
  output logic                         hresp_o
);
  import mam_pkg::*;

  logic [MAM_XLEN-1:0]                mem_q [MAM_MEM_WORDS];
  logic [$clog2(MAM_WAIT+1)-1:0]      wait_q;
  logic [$clog2(MAM_MEM_WORDS)-1:0]   word_idx;

  // Word address, upper bits wrap around the array
  assign word_idx = haddr_i[$clog2(MAM_BYTES) +: $clog2(MAM_MEM_WORDS)];

  assign hready_o = hsel_i & (wait_q == MAM_WAIT);
  assign hrdata_o = mem_q[word_idx];
  assign hresp_o  = 1'b0;  // Always OKAY

  // Wait-state counter restarts for every beat
  always_ff @(posedge clk_i) begin
    if (rst_i || !hsel_i || hready_o) begin
      wait_q <= '0;
    end else begin
      wait_q <= wait_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (hready_o && hwrite_i) begin
      mem_q[word_idx] <= hwdata_i;
    end
  end

endmodule

/* source/mam_cmd_decode.sv */
`timescale 1ns/1ps

module mam_cmd_decode (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             cmd_valid_i,
  input  logic [mam_pkg::MAM_XLEN-1:0]     cmd_data_i,
  output logic                             cmd_ready_o,
  output logic                             req_valid_o,
  input  logic                             req_ready_i,
  output logic                             req_we_o,
  output logic [mam_pkg::MAM_PLEN-1:0]     req_addr_o,
  output logic                             req_burst_o,
  output logic [mam_pkg::MAM_BEATS_W-1:0]  req_beats_o,
  output logic                             write_valid_o,
  output logic [mam_pkg::MAM_XLEN-1:0]     write_data_o,
  input  logic                             write_ready_i
);
  import mam_pkg::*;

  mam_dec_state_e state_q;
  mam_dec_state_e state_d;

  logic                   hdr_rdy_q;  // Ready to take header or address words
  logic                   cmd_fire;
  logic [MAM_BEATS_W-1:0] left_q;     // Write words still to forward

  assign cmd_fire    = cmd_valid_i & cmd_ready_o;
  assign cmd_ready_o = hdr_rdy_q | ((state_q == DEC_WDATA) & write_ready_i);
  assign req_valid_o = (state_q == DEC_ISSUE);

  // Write data passes straight through from the command stream
  assign write_valid_o = (state_q == DEC_WDATA) & cmd_valid_i;
  assign write_data_o  = cmd_data_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      DEC_HDR: begin
        if (cmd_fire) state_d = DEC_ADDR_HI;
      end
      DEC_ADDR_HI: begin
        if (cmd_fire) state_d = DEC_ADDR_LO;
      end
      DEC_ADDR_LO: begin
        if (cmd_fire) state_d = DEC_ISSUE;
      end
      DEC_ISSUE: begin
        if (req_ready_i) state_d = req_we_o ? DEC_WDATA : DEC_HDR;
      end
      DEC_WDATA: begin
        if (cmd_fire && left_q == MAM_BEATS_W'(1)) state_d = DEC_HDR;
      end
      default: state_d = DEC_HDR;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= DEC_HDR;
      hdr_rdy_q <= 1'b0;
      left_q    <= '0;
    end else begin
      state_q   <= state_d;
      hdr_rdy_q <= state_d inside {DEC_HDR, DEC_ADDR_HI, DEC_ADDR_LO};
      if (state_q == DEC_ISSUE && req_ready_i) begin
        left_q <= req_beats_o;
      end else if (state_q == DEC_WDATA && cmd_fire) begin
        left_q <= left_q - 1'b1;
      end
    end
  end

  // Request fields, loaded word by word
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      case (state_q)
        DEC_HDR: begin
          req_we_o    <= cmd_data_i[MAM_HDR_WE];
          req_burst_o <= cmd_data_i[MAM_HDR_BURST];
          // Single accesses always move one word
          req_beats_o <= cmd_data_i[MAM_HDR_BURST] ? cmd_data_i[MAM_BEATS_W-1:0]
                                                   : MAM_BEATS_W'(1);
        end
        DEC_ADDR_HI: req_addr_o[MAM_PLEN-1 -: MAM_XLEN] <= cmd_data_i;
        DEC_ADDR_LO: req_addr_o[MAM_XLEN-1:0]           <= cmd_data_i;
        default: ;
      endcase
    end
  end

endmodule

/* source/mam_pkg.sv */
package mam_pkg;

  // Bus geometry
  localparam int MAM_XLEN    = 16;
  localparam int MAM_PLEN    = 32;
  localparam int MAM_BYTES   = MAM_XLEN / 8;  // Address step per beat
  localparam int MAM_BEATS_W = 13;

  // Command header fields, beat count sits in the low MAM_BEATS_W bits
  localparam int MAM_HDR_WE    = 15;
  localparam int MAM_HDR_BURST = 14;

  // Memory model
  localparam int MAM_MEM_WORDS = 256;
  localparam int MAM_WAIT      = 1;  // Wait cycles before each hready

  localparam logic [MAM_XLEN-1:0] MAM_WR_ACK = 16'hAC00;

  typedef enum logic [2:0] {
    DEC_HDR,
    DEC_ADDR_HI,
    DEC_ADDR_LO,
    DEC_ISSUE,
    DEC_WDATA
  } mam_dec_state_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE_LAST,
    ST_WRITE_LAST_WAIT,
    ST_WRITE,
    ST_WRITE_WAIT,
    ST_READ,
    ST_READ_WAIT
  } mam_bus_state_e;

endpackage

/* source/mam_resp_gen.sv */
`timescale 1ns/1ps

module mam_resp_gen (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         read_valid_i,
  input  logic [mam_pkg::MAM_XLEN-1:0] read_data_i,
  output logic                         read_ready_o,
  input  logic                         wr_done_i,
  output logic                         resp_valid_o,
  output logic [mam_pkg::MAM_XLEN-1:0] resp_data_o,
  input  logic                         resp_ready_i
);
  import mam_pkg::*;

  logic                full_q;
  logic [MAM_XLEN-1:0] data_q;
  logic                rd_fire;

  assign rd_fire      = read_valid_i & read_ready_o;
  assign read_ready_o = ~full_q;  // Only take read data into an empty slot
  assign resp_valid_o = full_q;
  assign resp_data_o  = data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (rd_fire || wr_done_i) begin
      full_q <= 1'b1;
    end else if (resp_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Write completions turn into a fixed acknowledge word
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      data_q <= read_data_i;
    end else if (wr_done_i) begin
      data_q <= MAM_WR_ACK;
    end
  end

endmodule

/* source/mam_top.sv */
`timescale 1ns/1ps

module mam_top (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         cmd_valid_i,
  input  logic [mam_pkg::MAM_XLEN-1:0] cmd_data_i,
  output logic                         cmd_ready_o,
  output logic                         resp_valid_o,
  output logic [mam_pkg::MAM_XLEN-1:0] resp_data_o,
  input  logic                         resp_ready_i,
  output logic [2:0]                   ahb_hburst_o,
  output logic                         ahb_hsel_o
);
  import mam_pkg::*;

  // Request and write data from the decoder
  logic                   req_valid;
  logic                   req_ready;
  logic                   req_we;
  logic [MAM_PLEN-1:0]    req_addr;
  logic                   req_burst;
  logic [MAM_BEATS_W-1:0] req_beats;
  logic                   write_valid;
  logic [MAM_XLEN-1:0]    write_data;
  logic                   write_ready;

  logic                   read_valid;
  logic [MAM_XLEN-1:0]    read_data;
  logic                   read_ready;
  logic                   wr_done;

  // AHB between master and SRAM
  logic                   hsel;
  logic [MAM_PLEN-1:0]    haddr;
  logic [MAM_XLEN-1:0]    hwdata;
  logic [MAM_XLEN-1:0]    hrdata;
  logic                   hwrite;
  logic                   hready;
  logic                   hresp;

  assign ahb_hsel_o = hsel;

  mam_cmd_decode u_decode (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_data_i    (cmd_data_i),
    .cmd_ready_o   (cmd_ready_o),
    .req_valid_o   (req_valid),
    .req_ready_i   (req_ready),
    .req_we_o      (req_we),
    .req_addr_o    (req_addr),
    .req_burst_o   (req_burst),
    .req_beats_o   (req_beats),
    .write_valid_o (write_valid),
    .write_data_o  (write_data),
    .write_ready_i (write_ready)
  );

  mam_ahb_master u_master (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_valid_i      (req_valid),
    .req_ready_o      (req_ready),
    .req_we_i         (req_we),
    .req_addr_i       (req_addr),
    .req_burst_i      (req_burst),
    .req_beats_i      (req_beats),
    .write_valid_i    (write_valid),
    .write_data_i     (write_data),
    .write_ready_o    (write_ready),
    .read_valid_o     (read_valid),
    .read_data_o      (read_data),
    .read_ready_i     (read_ready),
    .wr_done_o        (wr_done),
    .ahb3_hsel_o      (hsel),
    .ahb3_haddr_o     (haddr),
    .ahb3_hwdata_o    (hwdata),
    .ahb3_hrdata_i    (hrdata),
    .ahb3_hwrite_o    (hwrite),
    .ahb3_hsize_o     (),
    .ahb3_hburst_o    (ahb_hburst_o),
    .ahb3_hprot_o     (),
    .ahb3_htrans_o    (),
    .ahb3_hmastlock_o (),
    .ahb3_hready_i    (hready),
    .ahb3_hresp_i     (hresp)
  );

  mam_resp_gen u_resp (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .read_valid_i (read_valid),
    .read_data_i  (read_data),
    .read_ready_o (read_ready),
    .wr_done_i    (wr_done),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o),
    .resp_ready_i (resp_ready_i)
  );

  mam_ahb_sram u_sram (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .hsel_i   (hsel),
    .haddr_i  (haddr),
    .hwdata_i (hwdata),
    .hwrite_i (hwrite),
    .hrdata_o (hrdata),
    .hready_o (hready),
    .hresp_o  (hresp)
  );

endmodule

/* verif/mam_tb.sv */
`timescale 1ns/1ps

module mam_tb;
  import mam_pkg::*;

  localparam int N_TESTS = 15;

  logic        clk_i;
  logic        rst_i;
  logic        cmd_valid_i;
  logic [15:0] cmd_data_i;
  logic        cmd_ready_o;
  logic        resp_valid_o;
  logic [15:0] resp_data_o;
  logic        resp_ready_i;
  logic [2:0]  ahb_hburst_o;
  logic        ahb_hsel_o;

  // Stimulus table with one access per entry
  logic        t_we    [N_TESTS];
  logic        t_burst [N_TESTS];
  int          t_beats [N_TESTS];  // Header beat field
  logic [31:0] t_addr  [N_TESTS];
  logic [15:0] t_seed  [N_TESTS];
  logic        t_bp    [N_TESTS];  // Random gaps and back-pressure

  logic [15:0] ref_mem [MAM_MEM_WORDS];
  logic [15:0] exp_q [$];

  integer rnd_seed;
  int     errors;
  int     checks;
  int     cycles = 0;
  int     limit;
  logic   one_beat;  // Access in flight moves a single word

  mam_top dut0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_data_i   (cmd_data_i),
    .cmd_ready_o  (cmd_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o),
    .resp_ready_i (resp_ready_i),
    .ahb_hburst_o (ahb_hburst_o),
    .ahb_hsel_o   (ahb_hsel_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic set_entry(input int i, input logic we, input logic burst, input int beats,
                           input logic [31:0] addr, input logic [15:0] dseed, input logic bp);
    t_we[i]    = we;
    t_burst[i] = burst;
    t_beats[i] = beats;
    t_addr[i]  = addr;
    t_seed[i]  = dseed;
    t_bp[i]    = bp;
  endtask

  task automatic load_table();
    set_entry(0,  1'b1, 1'b0, 3, 32'h0000_0010, 16'h1234, 1'b0);  // Beat field ignored
    set_entry(1,  1'b0, 1'b0, 1, 32'h0000_0010, 16'h0000, 1'b0);
    set_entry(2,  1'b1, 1'b1, 4, 32'h0000_0040, 16'hA000, 1'b0);
    set_entry(3,  1'b0, 1'b1, 4, 32'h0000_0040, 16'h0000, 1'b0);
    set_entry(4,  1'b1, 1'b1, 3, 32'h0000_0080, 16'h5500, 1'b0);  // Neighbours first
    set_entry(5,  1'b1, 1'b0, 1, 32'h0000_0082, 16'h0F0F, 1'b0);
    set_entry(6,  1'b0, 1'b1, 3, 32'h0000_0080, 16'h0000, 1'b0);
    set_entry(7,  1'b1, 1'b0, 1, 32'h1000_0202, 16'h7E57, 1'b0);  // Aliases word 1
    set_entry(8,  1'b0, 1'b0, 7, 32'h0000_0002, 16'h0000, 1'b0);
    set_entry(9,  1'b1, 1'b1, 6, 32'h0000_00C0, 16'h3C00, 1'b1);
    set_entry(10, 1'b0, 1'b1, 6, 32'h0000_00C0, 16'h0000, 1'b1);
    set_entry(11, 1'b1, 1'b1, 1, 32'h0000_0020, 16'hBEEF, 1'b0);
    set_entry(12, 1'b0, 1'b1, 1, 32'h0000_0020, 16'h0000, 1'b0);
    set_entry(13, 1'b1, 1'b1, 8, 32'h0000_01FC, 16'h6100, 1'b1);  // Wraps past the top
    set_entry(14, 1'b0, 1'b1, 8, 32'h0000_01FC, 16'h0000, 1'b1);
  endtask

  // Number of words the access moves on the bus
  function automatic int eff_beats(input int i);
    return t_burst[i] ? t_beats[i] : 1;
  endfunction

  function automatic logic [15:0] wr_word(input int i, input int k);
    return t_seed[i] + 16'(k) * 16'h0111;
  endfunction

  function automatic int word_index(input logic [31:0] addr);
    return int'((addr >> 1) % MAM_MEM_WORDS);
  endfunction

  // Called on a falling edge and returns on the falling edge after the transfer
  task automatic send_word(input logic [15:0] w);
    cmd_valid_i = 1'b1;
    cmd_data_i  = w;
    #1;
    while (!cmd_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
  endtask

  task automatic idle_gap(input logic bp);
    int n;
    n = bp ? int'($unsigned($random(rnd_seed)) % 4) : 0;
    if (n > 0) begin
      cmd_valid_i = 1'b0;
      repeat (n) @(negedge clk_i);
    end
  endtask

  task automatic drive_command(input int i);
    logic [15:0] hdr;
    hdr = {t_we[i], t_burst[i], 1'b0, 13'(t_beats[i])};  // Bit 13 is unused
    send_word(hdr);
    send_word(t_addr[i][31:16]);
    send_word(t_addr[i][15:0]);
    if (t_we[i]) begin
      for (int k = 0; k < eff_beats(i); k++) begin
        idle_gap(t_bp[i]);
        send_word(wr_word(i, k));
      end
    end
    cmd_valid_i = 1'b0;
  endtask

  task automatic collect_responses(input int i, input int n);
    int          got;
    logic        holding;
    logic [15:0] held;
    got     = 0;
    holding = 1'b0;
    held    = '0;
    while (got < n) begin
      @(negedge clk_i);
      resp_ready_i = t_bp[i] ? 1'($random(rnd_seed)) : 1'b1;
      #1;
      if (holding) begin  // Stalled word must not move
        check("resp_valid_o", resp_valid_o, 1'b1);
        check("resp_data_o", resp_data_o, held);
      end
      holding = resp_valid_o && !resp_ready_i;
      held    = resp_data_o;
      if (resp_valid_o && resp_ready_i) begin
        check("resp_data_o", resp_data_o, exp_q[got]);
        got++;
      end
    end
  endtask

  task automatic run_test(input int i);
    int n;
    int e0;
    n  = eff_beats(i);
    e0 = errors;
    exp_q.delete();
    if (t_we[i]) begin
      for (int k = 0; k < n; k++) ref_mem[word_index(t_addr[i] + 32'(2 * k))] = wr_word(i, k);
      exp_q.push_back(MAM_WR_ACK);
    end else begin
      for (int k = 0; k < n; k++) exp_q.push_back(ref_mem[word_index(t_addr[i] + 32'(2 * k))]);
    end
    one_beat = (n == 1);
    fork
      drive_command(i);
      collect_responses(i, exp_q.size());
    join
    one_beat = 1'b0;
    $display("test %0d: %s %s beats=%0d addr=%h, %s", i, t_we[i] ? "write" : "read",
             t_burst[i] ? "burst" : "single", n, t_addr[i], (errors == e0) ? "ok" : "mismatch");
  endtask

  // One-word accesses must show single/last on the bus
  always @(negedge clk_i) begin
    #2;
    if (one_beat && ahb_hsel_o) check("ahb_hburst_o", ahb_hburst_o, 3'b111);
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    rnd_seed     = 32'h01be0719;
    errors       = 0;
    checks       = 0;
    one_beat     = 1'b0;
    rst_i        = 1'b1;
    cmd_valid_i  = 1'b0;
    cmd_data_i   = '0;
    resp_ready_i = 1'b1;
    load_table();
    limit = 200;
    for (int i = 0; i < N_TESTS; i++) limit += eff_beats(i) * (MAM_WAIT + 6);

    repeat (5) @(negedge clk_i);
    check("cmd_ready_o", cmd_ready_o, 1'b0);
    check("resp_valid_o", resp_valid_o, 1'b0);
    check("ahb_hsel_o", ahb_hsel_o, 1'b0);
    rst_i = 1'b0;

    for (int i = 0; i < N_TESTS; i++) begin
      @(negedge clk_i);
      run_test(i);
    end

    // No stray response word after the last access
    repeat (8) begin
      @(negedge clk_i);
      #1;
      check("resp_valid_o", resp_valid_o, 1'b0);
    end

    $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
